/* sources.f */
hw/note_pkg.sv
hw/pitch_meter.sv
hw/note_classifier.sv
hw/note_stabilizer.sv
hw/note_queue.sv
hw/melody_tracker.sv
hw/note_recognizer_top.sv
test/tb_note_recognizer.sv

/* test/tb_note_recognizer.sv */
`timescale 1ns/1ps

module tb_note_recognizer
    import note_pkg::*;
();

    localparam int CLK_HZ        = 200_000;
    localparam int W_PERIOD      = 12;
    localparam int STABLE_CYCLES = 64;
    localparam int QUEUE_DEPTH   = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int SILENCE_LEN   = (1 << W_PERIOD) + STABLE_CYCLES + 100;  // Past saturation
    localparam int N_TONES       = 89;
    localparam int N_SILENCES    = 5;

    logic           clk = 1'b0;
    logic           rst;
    logic [23:0]    sample;
    pitch_t         o_note;
    melody_status_t o_status;

    logic [31:0]    lfsr = 32'h9530_5745;
    pitch_t         model_note;
    step_t          model_step [N_MELODIES];
    int             cycle_cnt = 0;
    int             timeout_limit = 32'h7fff_ffff;

    always #20 clk = ~clk;

    note_recognizer_top #(
        .CLK_HZ        (CLK_HZ),
        .W_PERIOD      (W_PERIOD),
        .STABLE_CYCLES (STABLE_CYCLES),
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) note_recognizer_top_i
    (
        .clk      (clk),
        .rst      (rst),
        .i_sample (sample),
        .o_note   (o_note),
        .o_status (o_status)
    );

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit)
        begin
            $display("Checks failed");
            $fatal(1, "Timeout after %0d cycles, the test sequence never finished", cycle_cnt);
        end
    end

    //--------------------------------------------------
    // Random numbers and tone shapes

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);  // Galois step
        end
        return r;
    endfunction

    function automatic logic [23:0] high_sample();
        logic [15:0] v;
        v = 16'(32'h1100 + rand_bits(16) % 32'hEF00);  // 0x1100 .. 0xFFFF
        return {v, 8'(rand_bits(8))};
    endfunction

    function automatic logic [23:0] low_sample();
        logic [15:0] v;
        v = 16'(rand_bits(16) % 32'h1100);
        return {v, 8'(rand_bits(8))};
    endfunction

    // Clocks per period of a note in an octave
    function automatic int ref_period(input int n, input int oct);
        return int'(longint'(CLK_HZ) * 100 / (longint'(FREQ_100[n]) << oct));
    endfunction

    function automatic int tone_cycles(input int p);
        return ((STABLE_CYCLES + 3 * p + 10 + p - 1) / p) * p;  // Whole periods only
    endfunction

    //--------------------------------------------------
    // Reference model

    function automatic pitch_t classify(input int period);
        pitch_t p;
        longint r;
        p = '0;
        for (int n = 0; n < N_NOTES; n++)
        begin
            for (int o = 0; o < 3; o++)
            begin
                r = ref_period(n, o);
                if (!p.valid && period > r * 96 / 100 && period < r * 104 / 100)
                    p = {1'b1, note_idx_t'(n)};
            end
        end
        return p;
    endfunction

    task automatic apply_pitch(input pitch_t p);
        if (p.valid && p != model_note)
        begin
            for (int m = 0; m < N_MELODIES; m++)  // Each song checks its next note
                if (model_step[m] != 4'hf && MELODY[m][model_step[m]] == p.idx)
                    model_step[m] = model_step[m] + 1'b1;
        end
        model_note = p;
    endtask

    function automatic melody_status_t expected_status();
        melody_status_t s;
        for (int m = 0; m < N_MELODIES; m++)
        begin
            s.step[m]  = model_step[m];
            s.found[m] = (model_step[m] == 4'hf);
        end
        s.all_found = &s.found;
        return s;
    endfunction

    //--------------------------------------------------
    // Compare tasks

    task automatic check_note(input pitch_t got, input pitch_t exp, input string name);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_status(input melody_status_t got, input melody_status_t exp,
                                input string name);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    //--------------------------------------------------
    // Stimulus

    task automatic check_outputs();
        @(negedge clk);  // Outputs settled
        check_note(o_note, model_note, "o_note");
        check_status(o_status, expected_status(), "o_status");
    endtask

    task automatic play_tone(input note_idx_t n, input int oct);
        int p;
        int cycles;
        p      = ref_period(n, oct) + 1;
        cycles = tone_cycles(p);
        for (int c = 0; c < cycles; c++)
        begin
            @(posedge clk);
            if ((c % p) < p / 2)
                sample <= high_sample();
            else
                sample <= low_sample();
        end
        apply_pitch(classify(p - 1));  // Measured period is one less
        check_outputs();
    endtask

    task automatic play_random();
        note_idx_t n;
        int        oct;
        n   = note_idx_t'(rand_bits(8) % 12);
        oct = int'(rand_bits(8) % 3);
        play_tone(n, oct);
    endtask

    task automatic play_silence();
        repeat (SILENCE_LEN)
        begin
            @(posedge clk);
            sample <= '0;
        end
        model_note = '0;
        check_outputs();
    endtask

    // Remaining notes of one song from its current step
    task automatic play_melody(input int m);
        for (int k = 0; k < MELODY_LEN && model_step[m] != 4'hf; k++)
            play_tone(MELODY[m][model_step[m]], int'(rand_bits(8) % 3));
    endtask

    initial
    begin
        int max_tone;
        rst    <= 1'b1;
        sample <= '0;
        model_note = '0;
        for (int m = 0; m < N_MELODIES; m++)
            model_step[m] = '0;

        max_tone = 0;
        for (int n = 0; n < N_NOTES; n++)
            for (int o = 0; o < 3; o++)
                if (tone_cycles(ref_period(n, o) + 1) > max_tone)
                    max_tone = tone_cycles(ref_period(n, o) + 1);
        timeout_limit = (N_TONES * max_tone + N_SILENCES * SILENCE_LEN + RESET_CYCLES) * 6 / 5;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        play_silence();  // Flush the first partial period

        // Note detection
        repeat (20) play_random();

        // Silence
        play_silence();

        // Song progress with distractors
        repeat (7)
        begin
            play_tone(MELODY[0][model_step[0]], int'(rand_bits(8) % 3));
            play_random();
        end

        // Full song
        play_silence();
        play_melody(1);

        // All found, then sticky
        play_silence();
        play_melody(0);
        play_silence();
        play_melody(2);
        repeat (10) play_random();

        $display("All checks passed");
        $finish;
    end

endmodule

/* hw/note_recognizer_top.sv */
`timescale 1ns/1ps

module note_recognizer_top
    import note_pkg::*;
#(
    parameter int CLK_HZ        = 50_000_000,
    parameter int W_PERIOD      = 20,
    parameter int STABLE_CYCLES = 262_144,
    parameter int QUEUE_DEPTH   = 4
)
(
    input                   clk,
    input                   rst,
    input        [23:0]     i_sample,
    output pitch_t          o_note,
    output melody_status_t  o_status
);

    logic [W_PERIOD - 1:0] period;
    pitch_t                pitch;
    logic                  push;
    note_idx_t             push_note;
    logic                  credit;
    logic                  avail;
    note_idx_t             head;
    logic                  pop;

    //--------------------------------------------------
    // Producer

    pitch_meter #(.W_PERIOD(W_PERIOD)) pitch_meter_i
    (
        .clk      (clk),
        .rst      (rst),
        .i_sample (i_sample),
        .o_period (period)
    );

    note_classifier #(.CLK_HZ(CLK_HZ), .W_PERIOD(W_PERIOD)) note_classifier_i
    (
        .clk      (clk),
        .rst      (rst),
        .i_period (period),
        .o_pitch  (pitch)
    );

    note_stabilizer #(.STABLE_CYCLES(STABLE_CYCLES), .QUEUE_DEPTH(QUEUE_DEPTH))
    note_stabilizer_i
    (
        .clk         (clk),
        .rst         (rst),
        .i_pitch     (pitch),
        .i_credit    (credit),
        .o_note      (o_note),
        .o_push      (push),
        .o_push_note (push_note)
    );

    //--------------------------------------------------
    // Queue and consumer

    note_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) note_queue_i
    (
        .clk         (clk),
        .rst         (rst),
        .i_push      (push),
        .i_push_note (push_note),
        .i_pop       (pop),
        .o_avail     (avail),
        .o_head      (head),
        .o_credit    (credit)
    );

    melody_tracker melody_tracker_i
    (
        .clk      (clk),
        .rst      (rst),
        .i_avail  (avail),
        .i_head   (head),
        .o_pop    (pop),
        .o_status (o_status)
    );

endmodule

/* hw/melody_tracker.sv */
`timescale 1ns/1ps

module melody_tracker
    import note_pkg::*;
(
    input                   clk,
    input                   rst,
    input                   i_avail,
    input  note_idx_t       i_head,
    output logic            o_pop,
    output melody_status_t  o_status
);

    localparam step_t STEP_FOUND = 4'hf;
    localparam int    W_SEL      = $clog2(N_MELODIES);

    step_t [N_MELODIES - 1:0] steps;
    note_idx_t                cur_note;  // Latched popped note
    logic                     busy;
    logic [W_SEL - 1:0]       sel;       // Melody being visited
    step_t                    cur_step;
    logic [3:0]               look_idx;
    note_idx_t                expected;
    logic                     advance;

    assign o_pop = !busy && i_avail;

    //--------------------------------------------------
    // Shared table lookup

    assign cur_step = steps [sel];
    assign look_idx = (cur_step < MELODY_LEN) ? cur_step : 4'd0;  // Keep index in range
    assign expected = MELODY [sel][look_idx];
    assign advance  = busy && (cur_step != STEP_FOUND) && (cur_note == expected);

    //--------------------------------------------------
    // Rotation over the melodies

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy  <= 1'b0;
            sel   <= '0;
            steps <= '0;
        end
        else if (!busy)
        begin
            sel <= '0;
            if (i_avail)
                busy <= 1'b1;
        end
        else
        begin
            if (advance)
                steps [sel] <= cur_step + 1'b1;  // Step 15 stays

            if (sel == W_SEL'(N_MELODIES - 1))
                busy <= 1'b0;
            else
                sel <= sel + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_pop)
            cur_note <= i_head;
    end

    always_comb
    begin
        o_status.step = steps;
        for (int m = 0; m < N_MELODIES; m++)
            o_status.found [m] = (steps [m] == STEP_FOUND);
        o_status.all_found = &o_status.found;
    end

endmodule

/* hw/note_queue.sv */
`timescale 1ns/1ps

module note_queue
    import note_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input               clk,
    input               rst,
    input               i_push,
    input  note_idx_t   i_push_note,
    input               i_pop,
    output logic        o_avail,
    output note_idx_t   o_head,
    output logic        o_credit
);

    localparam int W_PTR = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int W_CNT = $clog2(QUEUE_DEPTH + 1);

    note_idx_t          mem [QUEUE_DEPTH];
    logic [W_PTR - 1:0] wr_ptr;
    logic [W_PTR - 1:0] rd_ptr;
    logic [W_CNT - 1:0] count;
    logic               pop_ok;

    assign o_avail = (count != '0);
    assign o_head  = mem [rd_ptr];
    assign pop_ok  = i_pop && o_avail;

    //--------------------------------------------------
    // Pointers, occupancy and credit return

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= (wr_ptr == W_PTR'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

            if (pop_ok)
                rd_ptr <= (rd_ptr == W_PTR'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            count    <= count + W_CNT'(i_push) - W_CNT'(pop_ok);
            o_credit <= pop_ok;  // One credit per pop
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_push)
            mem [wr_ptr] <= i_push_note;
    end

endmodule

/* hw/note_stabilizer.sv */
`timescale 1ns/1ps

module note_stabilizer
    import note_pkg::*;
#(
    parameter int STABLE_CYCLES = 262_144,
    parameter int QUEUE_DEPTH   = 4
)
(
    input               clk,
    input               rst,
    input  pitch_t      i_pitch,
    input               i_credit,
    output pitch_t      o_note,
    output logic        o_push,
    output note_idx_t   o_push_note
);

    localparam int W_CNT  = (STABLE_CYCLES > 1) ? $clog2(STABLE_CYCLES) : 1;
    localparam int W_CRED = $clog2(QUEUE_DEPTH + 1);

    pitch_t              d_pitch;       // Delayed pitch
    logic [W_CNT - 1:0]  stable_cnt;
    logic                stable_hit;
    logic                new_event;
    logic                pending;
    note_idx_t           pending_note;  // Waits here without credit
    logic [W_CRED - 1:0] credits;

    assign stable_hit = (i_pitch == d_pitch) && (stable_cnt == W_CNT'(STABLE_CYCLES - 1));
    assign new_event  = stable_hit && d_pitch.valid && (d_pitch != o_note);

    assign o_push      = pending && (credits != '0);
    assign o_push_note = pending_note;

    //--------------------------------------------------
    // Stability filter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            d_pitch    <= '0;
            stable_cnt <= '0;
            o_note     <= '0;
        end
        else
        begin
            d_pitch <= i_pitch;

            if (i_pitch != d_pitch)
                stable_cnt <= '0;
            else if (!stable_hit)
                stable_cnt <= stable_cnt + 1'b1;

            if (stable_hit)
                o_note <= d_pitch;
        end
    end

    //--------------------------------------------------
    // Pending event and credit count

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pending <= 1'b0;
            credits <= W_CRED'(QUEUE_DEPTH);
        end
        else
        begin
            if (new_event)
                pending <= 1'b1;  // Newer note overwrites an unsent one
            else if (o_push)
                pending <= 1'b0;

            credits <= credits - W_CRED'(o_push) + W_CRED'(i_credit);
        end
    end

    always_ff @(posedge clk)
    begin
        if (new_event)
            pending_note <= d_pitch.idx;
    end

endmodule

/* hw/note_classifier.sv */
`timescale 1ns/1ps

module note_classifier
    import note_pkg::*;
#(
    parameter int CLK_HZ   = 50_000_000,
    parameter int W_PERIOD = 20
)
(
    input                         clk,
    input                         rst,
    input        [W_PERIOD - 1:0] i_period,
    output pitch_t                o_pitch
);

    localparam int N_OCTAVES = 3;

    logic [N_NOTES - 1:0] hit;
    pitch_t               match;

    //--------------------------------------------------
    // Window check per note and octave

    for (genvar n = 0; n < N_NOTES; n++)
    begin : g_note
        logic [N_OCTAVES - 1:0] oct_hit;

        for (genvar o = 0; o < N_OCTAVES; o++)
        begin : g_oct
            localparam longint unsigned FREQ = 64'(FREQ_100 [n]) << o;
            localparam longint unsigned REF  = 64'(CLK_HZ) * 100 / FREQ;  // Clocks per period
            localparam longint unsigned LO   = REF * 96 / 100;
            localparam longint unsigned HI   = REF * 104 / 100;

            assign oct_hit [o] = (64'(i_period) > LO) && (64'(i_period) < HI);
        end

        assign hit [n] = |oct_hit;
    end

    // Lowest matching index wins
    always_comb
    begin
        match = '0;
        for (int n = N_NOTES - 1; n >= 0; n--)
        begin
            if (hit [n])
            begin
                match.valid = 1'b1;
                match.idx   = note_idx_t'(n);
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            o_pitch <= '0;
        else
            o_pitch <= match;
    end

endmodule

/* hw/pitch_meter.sv */
`timescale 1ns/1ps

module pitch_meter
    import note_pkg::*;
#(
    parameter int W_PERIOD = 20
)
(
    input                         clk,
    input                         rst,
    input        [23:0]           i_sample,
    output logic [W_PERIOD - 1:0] o_period
);

    logic [15:0]           value;
    logic [15:0]           prev_value;
    logic [W_PERIOD - 1:0] counter;
    logic                  rising;
    logic                  saturated;

    assign value     = i_sample [23:8];
    assign saturated = &counter;

    // Upward crossing of the threshold
    assign rising = (value >= SAMPLE_THRESHOLD) && (prev_value < SAMPLE_THRESHOLD);

    //--------------------------------------------------
    // Period between crossings

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            prev_value <= '0;
            counter    <= '0;
            o_period   <= '0;
        end
        else
        begin
            prev_value <= value;

            if (rising)
            begin
                o_period <= counter;  // Cycles between crossings minus one
                counter  <= '0;
            end
            else if (!saturated)
                counter <= counter + 1'b1;
            else
                o_period <= '1;  // Silence, matches no note window
        end
    end

endmodule

/* hw/note_pkg.sv */
package note_pkg;

    localparam int N_NOTES    = 12;
    localparam int N_MELODIES = 3;
    localparam int MELODY_LEN = 15;

    typedef logic [3:0] note_idx_t;  // C = 0 .. B = 11
    typedef logic [3:0] step_t;      // 15 means song found

    typedef struct packed
    {
        logic      valid;
        note_idx_t idx;
    } pitch_t;

    typedef struct packed
    {
        step_t [N_MELODIES - 1:0] step;
        logic  [N_MELODIES - 1:0] found;
        logic                     all_found;
    } melody_status_t;

    //--------------------------------------------------
    // Note indices

    localparam note_idx_t NOTE_C  = 4'd0,  NOTE_CS = 4'd1,
                          NOTE_D  = 4'd2,  NOTE_DS = 4'd3,
                          NOTE_E  = 4'd4,  NOTE_F  = 4'd5,
                          NOTE_FS = 4'd6,  NOTE_G  = 4'd7,
                          NOTE_GS = 4'd8,  NOTE_A  = 4'd9,
                          NOTE_AS = 4'd10, NOTE_B  = 4'd11;

    // Lowest octave, hundredths of a hertz
    localparam logic [18:0] FREQ_100 [N_NOTES] = '{
        19'd26163, 19'd27718, 19'd29366, 19'd31113, 19'd32963, 19'd34923,
        19'd36999, 19'd39200, 19'd41530, 19'd44000, 19'd46616, 19'd49388
    };

    //--------------------------------------------------
    // Song set

    localparam note_idx_t MELODY [N_MELODIES][MELODY_LEN] = '{
        // The story of love
        '{NOTE_AS, NOTE_D,  NOTE_AS, NOTE_D,  NOTE_DS, NOTE_D,  NOTE_C,  NOTE_A,
          NOTE_C,  NOTE_A,  NOTE_C,  NOTE_D,  NOTE_C,  NOTE_AS, NOTE_G},
        // Godfather
        '{NOTE_G,  NOTE_C,  NOTE_DS, NOTE_D,  NOTE_C,  NOTE_DS, NOTE_C,  NOTE_D,
          NOTE_C,  NOTE_GS, NOTE_AS, NOTE_G,  NOTE_C,  NOTE_DS, NOTE_D},
        // Gangsters song
        '{NOTE_E,  NOTE_F,  NOTE_E,  NOTE_A,  NOTE_B,  NOTE_C,  NOTE_D,  NOTE_C,
          NOTE_B,  NOTE_C,  NOTE_G,  NOTE_C,  NOTE_A,  NOTE_C,  NOTE_A}
    };

    localparam logic [15:0] SAMPLE_THRESHOLD = 16'h1100;  // On sample bits 23:8

endpackage
